//--- pve_mem_pkg.sv
`default_nettype none

package pve_mem_pkg;

  //////////////////////////////
  // Default sizes
  //////////////////////////////

  // Banks and lanes, power of two
  parameter int unsigned PVE_MEM_NUM_BANKS  = 4;
  // Rows in each bank
  parameter int unsigned PVE_MEM_BANK_DEPTH = 64;

  //////////////////////////////
  // Field widths
  //////////////////////////////

  parameter int unsigned PVE_MEM_DATA_W = 32;
  parameter int unsigned PVE_MEM_BE_W   = PVE_MEM_DATA_W / 8;
  // Wider than the default region so out-of-range words are reachable
  parameter int unsigned PVE_MEM_ADDR_W = 10;

  //////////////////////////////
  // Lane types
  //////////////////////////////

  // One lane of data
  typedef logic [PVE_MEM_DATA_W-1:0] pve_mem_data_t;

  // Byte enables of one lane
  typedef logic [PVE_MEM_BE_W-1:0]   pve_mem_be_t;

  // Word address, not byte address
  typedef logic [PVE_MEM_ADDR_W-1:0] pve_mem_addr_t;

endpackage : pve_mem_pkg

`default_nettype wire

//--- pve_mem_req_dist.sv
`timescale 1ns/1ps
`default_nettype none

module pve_mem_req_dist #(
  parameter int unsigned NUM_BANKS  = pve_mem_pkg::PVE_MEM_NUM_BANKS,
  parameter int unsigned BANK_DEPTH = pve_mem_pkg::PVE_MEM_BANK_DEPTH
) (
  input  wire                                          i_clk,
  input  wire                                          i_arst_n,
  // Vector request
  input  logic                                         i_req_valid,
  input  pve_mem_pkg::pve_mem_addr_t                   i_req_addr,
  input  logic                                         i_req_we,
  input  pve_mem_pkg::pve_mem_be_t   [NUM_BANKS-1:0]   i_req_be,
  input  pve_mem_pkg::pve_mem_data_t [NUM_BANKS-1:0]   i_req_wdata,
  output logic                                         o_req_ready,
  // Bank requests
  input  logic [NUM_BANKS-1:0]                         i_bank_ready,
  output logic [NUM_BANKS-1:0]                         o_bank_valid,
  output logic [NUM_BANKS-1:0][$clog2(BANK_DEPTH)-1:0] o_bank_row,
  output logic [NUM_BANKS-1:0]                         o_bank_oor,
  output logic [NUM_BANKS-1:0]                         o_bank_we,
  output pve_mem_pkg::pve_mem_be_t   [NUM_BANKS-1:0]   o_bank_be,
  output pve_mem_pkg::pve_mem_data_t [NUM_BANKS-1:0]   o_bank_wdata,
  // Rotation FIFO, read side
  input  logic                                         i_rot_pop,
  output logic [$clog2(NUM_BANKS)-1:0]                 o_rot_head,
  output logic                                         o_rot_empty
);
  import pve_mem_pkg::*;

  localparam int unsigned ROT_W     = $clog2(NUM_BANKS);
  localparam int unsigned ROW_W     = $clog2(BANK_DEPTH);
  localparam int unsigned ADDR_W    = $bits(pve_mem_addr_t);
  localparam int unsigned WORDS     = NUM_BANKS * BANK_DEPTH;
  localparam int unsigned ROT_DEPTH = 4;
  localparam int unsigned PTR_W     = $clog2(ROT_DEPTH);
  localparam int unsigned CNT_W     = PTR_W + 1;

  typedef logic [ROT_W-1:0] rot_t;
  // One extra bit so base plus lane index cannot wrap
  typedef logic [ADDR_W:0]  word_addr_t;

  rot_t req_rot;
  logic req_fire;
  logic rot_full;

  rot_t             rot_mem [ROT_DEPTH];
  logic [PTR_W-1:0] rot_wr_ptr;
  logic [PTR_W-1:0] rot_rd_ptr;
  logic [CNT_W-1:0] rot_count;

  //////////////////////////////
  // Handshake
  //////////////////////////////

  // Base mod NUM_BANKS is the bank that lane 0 lands on
  assign req_rot = rot_t'(i_req_addr);

  // All banks take the vector in the same cycle or none does
  assign o_req_ready = (&i_bank_ready) & ~rot_full;
  assign req_fire    = i_req_valid & o_req_ready;

  //////////////////////////////
  // Lane to bank routing
  //////////////////////////////

  always_comb begin
    rot_t       lane;
    word_addr_t word;
    for (int unsigned b = 0; b < NUM_BANKS; b++) begin
      // Lane whose word falls into bank b
      lane            = rot_t'(b) - req_rot;
      word            = word_addr_t'(i_req_addr) + word_addr_t'(lane);
      o_bank_row[b]   = ROW_W'(word >> ROT_W);
      o_bank_oor[b]   = (word >= WORDS);
      o_bank_we[b]    = i_req_we;
      o_bank_be[b]    = i_req_be[lane];
      o_bank_wdata[b] = i_req_wdata[lane];
      o_bank_valid[b] = req_fire;
    end
  end

  //////////////////////////////
  // Rotation FIFO
  //////////////////////////////

  assign rot_full    = (rot_count == CNT_W'(ROT_DEPTH));
  assign o_rot_empty = (rot_count == '0);
  assign o_rot_head  = rot_mem[rot_rd_ptr];

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      rot_wr_ptr <= '0;
      rot_rd_ptr <= '0;
      rot_count  <= '0;
    end else begin
      if (req_fire) begin
        rot_wr_ptr <= rot_wr_ptr + 1'b1;
      end
      if (i_rot_pop) begin
        rot_rd_ptr <= rot_rd_ptr + 1'b1;
      end
      rot_count <= rot_count + CNT_W'(req_fire) - CNT_W'(i_rot_pop);
    end
  end

  always_ff @(posedge i_clk) begin
    if (req_fire) begin
      rot_mem[rot_wr_ptr] <= req_rot;
    end
  end

endmodule : pve_mem_req_dist

`default_nettype wire

//--- pve_mem_bank_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module pve_mem_bank_ctrl #(
  parameter int unsigned BANK_DEPTH = pve_mem_pkg::PVE_MEM_BANK_DEPTH
) (
  input  wire                           i_clk,
  input  wire                           i_arst_n,
  // Request from the distributor
  input  logic                          i_req_valid,
  input  logic [$clog2(BANK_DEPTH)-1:0] i_req_row,
  input  logic                          i_req_oor,
  input  logic                          i_req_we,
  input  pve_mem_pkg::pve_mem_be_t      i_req_be,
  input  pve_mem_pkg::pve_mem_data_t    i_req_wdata,
  output logic                          o_req_ready,
  // Response to the collector
  output logic                          o_rsp_valid,
  input  logic                          i_rsp_ready,
  output pve_mem_pkg::pve_mem_data_t    o_rsp_rdata,
  output logic                          o_rsp_err
);
  import pve_mem_pkg::*;

  localparam int unsigned BE_W       = $bits(pve_mem_be_t);
  localparam int unsigned FIFO_DEPTH = 2;
  localparam int unsigned PTR_W      = $clog2(FIFO_DEPTH);
  localparam int unsigned CNT_W      = PTR_W + 1;

  pve_mem_data_t mem [BANK_DEPTH];

  logic req_fire;
  logic rsp_pop;

  // Read stage, one entry in flight
  logic          rd_valid_q;
  pve_mem_data_t rd_data_q;
  logic          rd_err_q;

  pve_mem_data_t    fifo_data [FIFO_DEPTH];
  logic             fifo_err  [FIFO_DEPTH];
  logic [PTR_W-1:0] fifo_wr_ptr;
  logic [PTR_W-1:0] fifo_rd_ptr;
  logic [CNT_W-1:0] fifo_count;
  logic [CNT_W-1:0] occupancy;

  //////////////////////////////
  // Flow control
  //////////////////////////////

  assign rsp_pop   = o_rsp_valid & i_rsp_ready;
  assign occupancy = fifo_count + CNT_W'(rd_valid_q);

  // A pop in this cycle frees the slot needed by the next read
  assign o_req_ready = (occupancy < CNT_W'(FIFO_DEPTH)) | rsp_pop;
  assign req_fire    = i_req_valid & o_req_ready;

  //////////////////////////////
  // SRAM array
  //////////////////////////////

  always_ff @(posedge i_clk) begin
    if (req_fire && i_req_we && !i_req_oor) begin
      for (int unsigned i = 0; i < BE_W; i++) begin
        if (i_req_be[i]) begin
          mem[i_req_row][i*8 +: 8] <= i_req_wdata[i*8 +: 8];
        end
      end
    end
  end

  // Writes and out-of-range accesses answer with zero data
  always_ff @(posedge i_clk) begin
    if (req_fire) begin
      rd_err_q <= i_req_oor;
      if (i_req_we || i_req_oor) begin
        rd_data_q <= '0;
      end else begin
        rd_data_q <= mem[i_req_row];
      end
    end
  end

  //////////////////////////////
  // Response FIFO
  //////////////////////////////

  assign o_rsp_valid = (fifo_count != '0);
  assign o_rsp_rdata = fifo_data[fifo_rd_ptr];
  assign o_rsp_err   = fifo_err[fifo_rd_ptr];

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      rd_valid_q  <= 1'b0;
      fifo_wr_ptr <= '0;
      fifo_rd_ptr <= '0;
      fifo_count  <= '0;
    end else begin
      rd_valid_q <= req_fire;
      if (rd_valid_q) begin
        fifo_wr_ptr <= fifo_wr_ptr + 1'b1;
      end
      if (rsp_pop) begin
        fifo_rd_ptr <= fifo_rd_ptr + 1'b1;
      end
      fifo_count <= fifo_count + CNT_W'(rd_valid_q) - CNT_W'(rsp_pop);
    end
  end

  // Read result lands in the FIFO one cycle after acceptance
  always_ff @(posedge i_clk) begin
    if (rd_valid_q) begin
      fifo_data[fifo_wr_ptr] <= rd_data_q;
      fifo_err[fifo_wr_ptr]  <= rd_err_q;
    end
  end

endmodule : pve_mem_bank_ctrl

`default_nettype wire

//--- pve_mem_rsp_collect.sv
`timescale 1ns/1ps
`default_nettype none

module pve_mem_rsp_collect #(
  parameter int unsigned NUM_BANKS = pve_mem_pkg::PVE_MEM_NUM_BANKS
) (
  // Bank responses
  input  logic [NUM_BANKS-1:0]                       i_bank_valid,
  input  pve_mem_pkg::pve_mem_data_t [NUM_BANKS-1:0] i_bank_rdata,
  input  logic [NUM_BANKS-1:0]                       i_bank_err,
  output logic [NUM_BANKS-1:0]                       o_bank_ready,
  // Rotation FIFO head
  input  logic [$clog2(NUM_BANKS)-1:0]               i_rot_head,
  input  logic                                       i_rot_empty,
  output logic                                       o_rot_pop,
  // Vector response
  output logic                                       o_rsp_valid,
  input  logic                                       i_rsp_ready,
  output pve_mem_pkg::pve_mem_data_t [NUM_BANKS-1:0] o_rsp_rdata,
  output logic [NUM_BANKS-1:0]                       o_rsp_err
);

  localparam int unsigned ROT_W = $clog2(NUM_BANKS);

  typedef logic [ROT_W-1:0] rot_t;

  logic rsp_fire;

  //////////////////////////////
  // Join and release
  //////////////////////////////

  // Vector is complete once every bank holds its element
  assign o_rsp_valid = (&i_bank_valid) & ~i_rot_empty;
  assign rsp_fire    = o_rsp_valid & i_rsp_ready;

  // Banks and rotation FIFO advance together
  assign o_bank_ready = {NUM_BANKS{rsp_fire}};
  assign o_rot_pop    = rsp_fire;

  //////////////////////////////
  // Undo the rotation
  //////////////////////////////

  always_comb begin
    rot_t bank;
    for (int unsigned l = 0; l < NUM_BANKS; l++) begin
      // Lane l was stored in bank (l + base) mod NUM_BANKS
      bank           = rot_t'(l) + i_rot_head;
      o_rsp_rdata[l] = i_bank_rdata[bank];
      o_rsp_err[l]   = i_bank_err[bank];
    end
  end

endmodule : pve_mem_rsp_collect

`default_nettype wire

//--- pve_mem_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module pve_mem_subsys #(
  parameter int unsigned NUM_BANKS  = pve_mem_pkg::PVE_MEM_NUM_BANKS,
  parameter int unsigned BANK_DEPTH = pve_mem_pkg::PVE_MEM_BANK_DEPTH
) (
  input  wire                                        i_clk,
  input  wire                                        i_arst_n,
  // Vector request
  input  logic                                       i_req_valid,
  input  pve_mem_pkg::pve_mem_addr_t                 i_req_addr,
  input  logic                                       i_req_we,
  input  pve_mem_pkg::pve_mem_be_t   [NUM_BANKS-1:0] i_req_be,
  input  pve_mem_pkg::pve_mem_data_t [NUM_BANKS-1:0] i_req_wdata,
  output logic                                       o_req_ready,
  // Vector response
  output logic                                       o_rsp_valid,
  output pve_mem_pkg::pve_mem_data_t [NUM_BANKS-1:0] o_rsp_rdata,
  output logic [NUM_BANKS-1:0]                       o_rsp_err,
  input  logic                                       i_rsp_ready
);
  import pve_mem_pkg::*;

  localparam int unsigned ROT_W = $clog2(NUM_BANKS);
  localparam int unsigned ROW_W = $clog2(BANK_DEPTH);

  // Distributor to banks
  logic          [NUM_BANKS-1:0]            bank_req_valid;
  logic          [NUM_BANKS-1:0]            bank_req_ready;
  logic          [NUM_BANKS-1:0][ROW_W-1:0] bank_req_row;
  logic          [NUM_BANKS-1:0]            bank_req_oor;
  logic          [NUM_BANKS-1:0]            bank_req_we;
  pve_mem_be_t   [NUM_BANKS-1:0]            bank_req_be;
  pve_mem_data_t [NUM_BANKS-1:0]            bank_req_wdata;

  // Banks to collector
  logic          [NUM_BANKS-1:0]            bank_rsp_valid;
  logic          [NUM_BANKS-1:0]            bank_rsp_ready;
  pve_mem_data_t [NUM_BANKS-1:0]            bank_rsp_rdata;
  logic          [NUM_BANKS-1:0]            bank_rsp_err;

  // Rotation FIFO
  logic [ROT_W-1:0] rot_head;
  logic             rot_pop;
  logic             rot_empty;

  //////////////////////////////
  // Request side
  //////////////////////////////

  pve_mem_req_dist #(
    .NUM_BANKS  ( NUM_BANKS  ),
    .BANK_DEPTH ( BANK_DEPTH )
  ) u_req_dist (
    .i_clk,
    .i_arst_n,
    .i_req_valid,
    .i_req_addr,
    .i_req_we,
    .i_req_be,
    .i_req_wdata,
    .o_req_ready,
    .i_bank_ready ( bank_req_ready ),
    .o_bank_valid ( bank_req_valid ),
    .o_bank_row   ( bank_req_row   ),
    .o_bank_oor   ( bank_req_oor   ),
    .o_bank_we    ( bank_req_we    ),
    .o_bank_be    ( bank_req_be    ),
    .o_bank_wdata ( bank_req_wdata ),
    .i_rot_pop    ( rot_pop        ),
    .o_rot_head   ( rot_head       ),
    .o_rot_empty  ( rot_empty      )
  );

  //////////////////////////////
  // Banks
  //////////////////////////////

  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    pve_mem_bank_ctrl #(
      .BANK_DEPTH ( BANK_DEPTH )
    ) u_bank (
      .i_clk,
      .i_arst_n,
      .i_req_valid ( bank_req_valid[b] ),
      .i_req_row   ( bank_req_row[b]   ),
      .i_req_oor   ( bank_req_oor[b]   ),
      .i_req_we    ( bank_req_we[b]    ),
      .i_req_be    ( bank_req_be[b]    ),
      .i_req_wdata ( bank_req_wdata[b] ),
      .o_req_ready ( bank_req_ready[b] ),
      .o_rsp_valid ( bank_rsp_valid[b] ),
      .i_rsp_ready ( bank_rsp_ready[b] ),
      .o_rsp_rdata ( bank_rsp_rdata[b] ),
      .o_rsp_err   ( bank_rsp_err[b]   )
    );
  end

  //////////////////////////////
  // Response side
  //////////////////////////////

  pve_mem_rsp_collect #(
    .NUM_BANKS ( NUM_BANKS )
  ) u_rsp_collect (
    .i_bank_valid ( bank_rsp_valid ),
    .i_bank_rdata ( bank_rsp_rdata ),
    .i_bank_err   ( bank_rsp_err   ),
    .o_bank_ready ( bank_rsp_ready ),
    .i_rot_head   ( rot_head       ),
    .i_rot_empty  ( rot_empty      ),
    .o_rot_pop    ( rot_pop        ),
    .o_rsp_valid,
    .i_rsp_ready,
    .o_rsp_rdata,
    .o_rsp_err
  );

endmodule : pve_mem_subsys

`default_nettype wire

//--- tb_pve_mem_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pve_mem_subsys;
  import pve_mem_pkg::*;

  localparam int LANES          = PVE_MEM_NUM_BANKS;
  localparam int REGION_WORDS   = PVE_MEM_NUM_BANKS * PVE_MEM_BANK_DEPTH;
  localparam int IDX_W          = $clog2(REGION_WORDS);
  localparam int BYTES          = $bits(pve_mem_be_t);
  localparam int TIMEOUT_CYCLES = 200;
  // Negedges from the accepting edge until the response shows
  localparam int RSP_EDGES      = 2;
  localparam int BP_EXTRA       = 6;

  typedef pve_mem_data_t [LANES-1:0] vec_data_t;
  typedef pve_mem_be_t   [LANES-1:0] vec_be_t;

  logic             clk = 1'b0;
  logic             arst_n;
  logic             req_valid;
  pve_mem_addr_t    req_addr;
  logic             req_we;
  vec_be_t          req_be;
  vec_data_t        req_wdata;
  logic             req_ready;
  logic             rsp_valid;
  vec_data_t        rsp_rdata;
  logic [LANES-1:0] rsp_err;
  logic             rsp_ready;

  // Reference model of the in-range words
  pve_mem_data_t    ref_mem [REGION_WORDS];
  vec_data_t        exp_rdata_q [$];
  logic [LANES-1:0] exp_err_q   [$];

  logic [31:0] lcg_state   = 32'ha4412778;
  string       test_name   = "reset";
  int          error_count = 0;
  int          acc_count   = 0;
  int          rsp_count   = 0;
  logic        abort_run   = 1'b0;
  string       abort_msg;

  pve_mem_subsys i_pve_mem_subsys (
    .i_clk       ( clk       ),
    .i_arst_n    ( arst_n    ),
    .i_req_valid ( req_valid ),
    .i_req_addr  ( req_addr  ),
    .i_req_we    ( req_we    ),
    .i_req_be    ( req_be    ),
    .i_req_wdata ( req_wdata ),
    .o_req_ready ( req_ready ),
    .o_rsp_valid ( rsp_valid ),
    .o_rsp_rdata ( rsp_rdata ),
    .o_rsp_err   ( rsp_err   ),
    .i_rsp_ready ( rsp_ready )
  );

  always #5 clk = ~clk;

  //////////////////////////////
  // Helpers
  //////////////////////////////

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic vec_data_t rand_vec();
    vec_data_t v;
    for (int l = 0; l < LANES; l++) begin
      v[l] = next_rand();
    end
    return v;
  endfunction

  task automatic check_eq(input string what, input logic [127:0] exp_val,
                          input logic [127:0] act_val);
    assert (act_val === exp_val) else begin
      error_count++;
      $display("FAILED %s: %s expected %h actual %h", test_name, what, exp_val, act_val);
    end
  endtask

  // The watchdog process below ends the run
  task automatic raise_timeout(input string what);
    abort_msg = what;
    abort_run = 1'b1;
  endtask

  // Applies one accepted request to the model and queues its response
  task automatic model_accept(input pve_mem_addr_t addr, input logic we,
                              input vec_be_t be, input vec_data_t wdata);
    vec_data_t        exp_data;
    logic [LANES-1:0] exp_err;
    int               word;
    exp_data = '0;
    exp_err  = '0;
    for (int l = 0; l < LANES; l++) begin
      word = int'(addr) + l;
      if (word >= REGION_WORDS) begin
        exp_err[l] = 1'b1;
      end else if (we) begin
        for (int b = 0; b < BYTES; b++) begin
          if (be[l][b]) begin
            ref_mem[word[IDX_W-1:0]][b*8 +: 8] = wdata[l][b*8 +: 8];
          end
        end
      end else begin
        exp_data[l] = ref_mem[word[IDX_W-1:0]];
      end
    end
    exp_rdata_q.push_back(exp_data);
    exp_err_q.push_back(exp_err);
    acc_count++;
  endtask

  // Starts 1 ns after a rising edge and returns 1 ns after the accepting edge
  task automatic send_req(input pve_mem_addr_t addr, input logic we,
                          input vec_be_t be, input vec_data_t wdata);
    int cycles;
    req_valid = 1'b1;
    req_addr  = addr;
    req_we    = we;
    req_be    = be;
    req_wdata = wdata;
    cycles    = 0;
    @(negedge clk);
    while (!req_ready) begin
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        raise_timeout("request was never accepted");
      end
      @(negedge clk);
    end
    model_accept(addr, we, be, wdata);
    @(posedge clk);
    #1;
    req_valid = 1'b0;
  endtask

  task automatic check_latency();
    int edges;
    edges = 1;
    @(negedge clk);
    while (!rsp_valid) begin
      if (edges > TIMEOUT_CYCLES) begin
        raise_timeout("response never became valid");
      end
      @(negedge clk);
      edges++;
    end
    check_eq("response latency", 128'(RSP_EDGES), 128'(edges));
    @(posedge clk);
    #1;
  endtask

  task automatic single_access(input pve_mem_addr_t addr, input logic we,
                               input vec_be_t be, input vec_data_t wdata);
    send_req(addr, we, be, wdata);
    check_latency();
  endtask

  task automatic wait_drained();
    int cycles;
    cycles = 0;
    while (exp_rdata_q.size() != 0) begin
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        raise_timeout("outstanding responses never arrived");
      end
      @(posedge clk);
      #1;
    end
  endtask

  // Checks each response at the negedge before its handshake edge
  always @(negedge clk) begin
    if (arst_n && rsp_valid && rsp_ready) begin
      assert (exp_rdata_q.size() != 0) else begin
        error_count++;
        $display("ERROR %s: response arrived with no request outstanding", test_name);
      end
      if (exp_rdata_q.size() != 0) begin
        check_eq("read data", 128'(exp_rdata_q[0]), 128'(rsp_rdata));
        check_eq("error flags", 128'(exp_err_q[0]), 128'(rsp_err));
        void'(exp_rdata_q.pop_front());
        void'(exp_err_q.pop_front());
      end
      rsp_count++;
    end
  end

  //////////////////////////////
  // Directed tests
  //////////////////////////////

  task automatic check_reset_state();
    test_name = "reset_state";
    @(negedge clk);
    check_eq("o_rsp_valid", 128'(0), 128'(rsp_valid));
    check_eq("o_req_ready", 128'(1), 128'(req_ready));
    @(posedge clk);
    #1;
  endtask

  // Fills words 0 to 63 for the later tests
  task automatic aligned_write_read();
    test_name = "aligned";
    for (int b = 0; b < 64; b += 4) begin
      single_access(pve_mem_addr_t'(b), 1'b1, '1, rand_vec());
    end
    for (int b = 0; b < 64; b += 4) begin
      single_access(pve_mem_addr_t'(b), 1'b0, '0, '0);
    end
  endtask

  task automatic unaligned_base();
    pve_mem_addr_t bases [7] = '{10'd4, 10'd3, 10'd7, 10'd5, 10'd1, 10'd8, 10'd0};
    test_name = "unaligned";
    single_access(10'd3, 1'b1, '1, rand_vec());
    single_access(10'd5, 1'b1, '1, rand_vec());
    foreach (bases[i]) begin
      single_access(bases[i], 1'b0, '0, '0);
    end
  endtask

  task automatic byte_enables();
    logic [31:0] r;
    test_name = "byte_enables";
    single_access(10'd10, 1'b1, {4'b1011, 4'b1000, 4'b0110, 4'b0001}, rand_vec());
    r = next_rand();
    single_access(10'd11, 1'b1, r[15:0], rand_vec());
    single_access(10'd10, 1'b0, '0, '0);
    single_access(10'd12, 1'b0, '0, '0);
    single_access(10'd8, 1'b0, '0, '0);
  endtask

  // Words 256 and up alias low rows if a write slipped through
  task automatic out_of_range();
    pve_mem_addr_t bases [6] = '{10'd252, 10'd254, 10'd255, 10'd0, 10'd44, 10'd1020};
    test_name = "out_of_range";
    single_access(10'd252, 1'b1, '1, rand_vec());
    single_access(10'd254, 1'b1, '1, rand_vec());
    single_access(10'd300, 1'b1, '1, rand_vec());
    foreach (bases[i]) begin
      single_access(bases[i], 1'b0, '0, '0);
    end
  endtask

  task automatic backpressure_ordering();
    pve_mem_addr_t addr [BP_EXTRA];
    logic          we   [BP_EXTRA];
    vec_be_t       be   [BP_EXTRA];
    vec_data_t     data [BP_EXTRA];
    logic [31:0]   r;
    int            filled;
    int            cycles;
    logic          sends_done;
    test_name  = "backpressure";
    rsp_ready  = 1'b0;
    filled     = 0;
    cycles     = 0;
    sends_done = 1'b0;
    r          = next_rand();
    req_valid  = 1'b1;
    req_addr   = pve_mem_addr_t'(r % 32'd61);
    req_we     = r[20];
    req_be     = '1;
    req_wdata  = rand_vec();
    // Back to back until the banks stop accepting
    @(negedge clk);
    while (req_ready) begin
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        raise_timeout("request ready never fell while stalled");
      end
      model_accept(req_addr, req_we, req_be, req_wdata);
      filled++;
      @(posedge clk);
      #1;
      r         = next_rand();
      req_addr  = pve_mem_addr_t'(r % 32'd61);
      req_we    = r[20];
      req_wdata = rand_vec();
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    req_valid = 1'b0;
    check_eq("requests accepted while stalled", 128'(2), 128'(filled));
    for (int i = 0; i < BP_EXTRA; i++) begin
      r       = next_rand();
      addr[i] = pve_mem_addr_t'(r % 32'd61);
      we[i]   = r[20];
      be[i]   = r[31:16];
      data[i] = rand_vec();
    end
    cycles = 0;
    fork
      begin
        for (int i = 0; i < BP_EXTRA; i++) begin
          send_req(addr[i], we[i], be[i], data[i]);
        end
        sends_done = 1'b1;
      end
      begin
        while (!(sends_done && exp_rdata_q.size() == 0)) begin
          cycles++;
          if (cycles > TIMEOUT_CYCLES) begin
            raise_timeout("drain under toggling response ready stalled");
          end
          @(posedge clk);
          #1;
          r         = next_rand();
          rsp_ready = r[16];
        end
      end
    join
    rsp_ready = 1'b1;
    check_eq("responses received", 128'(acc_count), 128'(rsp_count));
  endtask

  //////////////////////////////
  // Sequence and summary
  //////////////////////////////

  initial begin : timeout_abort
    wait (abort_run);
    error_count++;
    $display("ERROR %s: %s", test_name, abort_msg);
    $display("Summary: %0d errors, %0d requests, %0d responses", error_count, acc_count,
             rsp_count);
    $display("Testbench failed");
    $finish;
  end

  initial begin
    arst_n    = 1'b0;
    req_valid = 1'b0;
    req_addr  = '0;
    req_we    = 1'b0;
    req_be    = '0;
    req_wdata = '0;
    rsp_ready = 1'b1;
    repeat (4) @(posedge clk);
    #1;
    arst_n = 1'b1;
    check_reset_state();
    aligned_write_read();
    unaligned_base();
    byte_enables();
    out_of_range();
    backpressure_ordering();
    wait_drained();
    $display("Summary: %0d errors, %0d requests, %0d responses", error_count, acc_count,
             rsp_count);
    if (error_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule : tb_pve_mem_subsys

`default_nettype wire

//--- pve_mem_subsys.f
pve_mem_pkg.sv
pve_mem_req_dist.sv
pve_mem_bank_ctrl.sv
pve_mem_rsp_collect.sv
pve_mem_subsys.sv
tb_pve_mem_subsys.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --timing --assert
TOP       ?= tb_pve_mem_subsys
FILELIST  ?= pve_mem_subsys.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Testbench passed

.PHONY: all lint sim clean

all: sim

# Static checks only, nothing is built
lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# Build, run and judge the result from the log
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation result: PASS"; \
	else \
		echo "Simulation result: FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
